/* rv32i_frontend.f */
rv32i_isa.sv
rv32i_types.sv
ir.sv
if_stage.sv
id_stage.sv
rv32i_frontend.sv
tb_rv32i_frontend.sv

/* Makefile */
# Verilator build and run of the RV32I front end testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv32i_frontend
FILELIST  ?= rv32i_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_rv32i_frontend.sv */
`timescale 1ns/1ps

module tb_rv32i_frontend
import rv32i_isa::*;
import rv32i_types::*;
;

    localparam logic [31:0] RESET_PC = 32'h6000_0000;
    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 16;
    localparam int N_TESTS     = 5;
    localparam int SEQ_LEN     = 13;
    localparam int STALL_LEN   = 12;
    localparam int REDIR_LEN   = 8;   // worst case before plus after the redirect.
    localparam int RAND_LEN    = 60;
    localparam int TOTAL_INSTS = 1 + SEQ_LEN + STALL_LEN + REDIR_LEN + RAND_LEN;
    localparam int WATCHDOG_NS =
        (TOTAL_INSTS * 8 + N_TESTS * (RST_CYCLES + 4)) * CLK_PERIOD;

    localparam logic [31:0] SEQ_PROG [SEQ_LEN] = '{
        32'h1234_52b7, 32'hffff_f317, 32'h0080_00ef, 32'hffc0_8167,
        32'hfe20_88e3, 32'h00c1_2383, 32'hfe71_2c23, 32'h0000_0013,
        32'h4020_81b3, 32'h0220_81b3, 32'hffff_ffff, 32'h0ff0_000f,
        32'h0000_0073
    };

    logic             clk;
    logic             rst;
    logic             stall;
    logic             pc_sel;
    logic [31:0]      pc_br_jp;
    logic [31:0]      imem_addr;
    imem_rmask_t      imem_rmask;
    logic [31:0]      imem_rdata;
    logic             imem_resp;
    id_ex_stage_reg_t id_ex;

    logic [31:0]      mem [256];
    logic [31:0]      rng_state = 32'h8e0f;
    int               lat_fixed = 0;     // zero means random latency.
    id_ex_stage_reg_t got [$];           // every new id_ex record.
    logic [31:0]      req_addrs [$];     // address of every request started.

    rv32i_frontend #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .pc_sel    (pc_sel),
        .pc_br_jp  (pc_br_jp),
        .imem_addr (imem_addr),
        .imem_rmask(imem_rmask),
        .imem_rdata(imem_rdata),
        .imem_resp (imem_resp),
        .id_ex     (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // addi built from a mix of every address bit.
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ {a[12:0], a[31:13]} ^ 32'h5bd1_e995;
        return {x[31:20], x[19:15], 3'b000, x[11:7], 7'b0010011};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [31:0] off;
        off = a - RESET_PC;
        if (off < 32'd1024) return mem[off[9:2]];
        return fill_word(a);
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [6:0]  opc;
        r = next_random();
        case (r[3:0])
            4'd0:    opc = 7'b0110111;
            4'd1:    opc = 7'b0010111;
            4'd2:    opc = 7'b1101111;
            4'd3:    opc = 7'b1100111;
            4'd4:    opc = 7'b1100011;
            4'd5:    opc = 7'b0000011;
            4'd6:    opc = 7'b0100011;
            4'd7:    opc = 7'b0010011;
            4'd8:    opc = 7'b0110011;
            4'd9:    opc = 7'b0001111;
            4'd10:   opc = 7'b1110011;
            default: opc = r[6:0];  // mostly illegal.
        endcase
        return {r[31:7], opc};
    endfunction

    // expected id_ex record straight from the RV32I encoding rules.
    function automatic id_ex_stage_reg_t ref_decode(input logic [31:0] pc,
                                                    input logic [63:0] order,
                                                    input logic [31:0] w);
        id_ex_stage_reg_t r;
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = pc;
        r.order   = order;
        r.inst    = w;
        r.rs1_s   = w[19:15];
        r.rs2_s   = w[24:20];
        r.rd_s    = w[11:7];
        r.funct3  = w[14:12];
        r.funct7  = w[31:25];
        r.imm_fmt = fmt_none;
        case (w[6:0])
            7'b0110111, 7'b0010111: begin
                r.imm_fmt   = fmt_u;
                r.imm       = {w[31:12], 12'b0};
                r.reg_write = 1'b1;
            end
            7'b1101111: begin
                r.imm_fmt   = fmt_j;
                r.imm       = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                r.reg_write = 1'b1;
                r.jump      = 1'b1;
            end
            7'b1100111: begin
                r.imm_fmt   = fmt_i;
                r.imm       = {{20{w[31]}}, w[31:20]};
                r.reg_write = 1'b1;
                r.jump      = 1'b1;
            end
            7'b1100011: begin
                r.imm_fmt = fmt_b;
                r.imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                r.branch  = 1'b1;
            end
            7'b0000011: begin
                r.imm_fmt   = fmt_i;
                r.imm       = {{20{w[31]}}, w[31:20]};
                r.reg_write = 1'b1;
                r.mem_read  = 1'b1;
            end
            7'b0100011: begin
                r.imm_fmt   = fmt_s;
                r.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
                r.mem_write = 1'b1;
            end
            7'b0010011: begin
                r.imm_fmt   = fmt_i;
                r.imm       = {{20{w[31]}}, w[31:20]};
                r.reg_write = 1'b1;
            end
            7'b0110011: begin
                if (w[31:25] == 7'h00 || w[31:25] == 7'h20) r.reg_write = 1'b1;
                else r.illegal = 1'b1;
            end
            7'b0001111, 7'b1110011: begin
                r.imm_fmt = fmt_none;
            end
            default: r.illegal = 1'b1;
        endcase
        if (w[11:7] == 5'd0) r.reg_write = 1'b0;  // x0 is never written.
        return r;
    endfunction

    task automatic check_id_ex(input string name, input id_ex_stage_reg_t exp,
                               input id_ex_stage_reg_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s: id_ex expected %h, actual %h",
                                        name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s: address expected %h, actual %h",
                                        name, exp, act));
        end
    endtask

    task automatic check_order(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s: order expected %0d, actual %0d",
                                        name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input imem_rmask_t exp,
                              input imem_rmask_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s: rmask expected %b, actual %b",
                                        name, exp, act));
        end
    endtask

    // instruction memory with 1 to 4 cycles of latency.
    initial begin
        logic        active;
        logic        waiting;
        logic [31:0] addr;
        int          lat_left;
        imem_resp  = 1'b0;
        imem_rdata = 32'h0;
        waiting    = 1'b0;
        lat_left   = 0;
        forever begin
            @(posedge clk);
            active = !rst && (imem_rmask != 4'b0000) && !imem_resp;
            addr   = imem_addr;
            if (rst) waiting = 1'b0;
            @(negedge clk);
            imem_resp = 1'b0;
            if (active) begin
                if (!waiting) begin
                    waiting  = 1'b1;
                    lat_left = (lat_fixed != 0) ? lat_fixed : int'(next_random() % 4) + 1;
                    req_addrs.push_back(addr);
                end
                lat_left--;
                if (lat_left == 0) begin
                    imem_resp  = 1'b1;
                    imem_rdata = read_word(addr);
                    waiting    = 1'b0;
                end
            end
        end
    end

    // collects each record that id_ex takes on.
    initial begin
        logic upd;
        forever begin
            @(posedge clk);
            upd = !stall;
            @(negedge clk);
            if (upd && !rst && id_ex.valid) got.push_back(id_ex);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before all tests completed");
    end

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) mem[i] = fill_word(RESET_PC + 32'(4 * i));
    endtask

    task automatic do_reset();
        @(negedge clk);
        rst    = 1'b1;
        stall  = 1'b0;
        pc_sel = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        got.delete();
        req_addrs.delete();
        rst = 1'b0;
    endtask

    task automatic wait_for_count(input int n);
        while (got.size() < n) @(negedge clk);
    endtask

    task automatic expect_run(input string name, input int first, input logic [31:0] pc0,
                              input logic [63:0] order0, input int count);
        id_ex_stage_reg_t exp;
        for (int i = 0; i < count; i++) begin
            exp = ref_decode(pc0 + 32'(4 * i), order0 + 64'(i), read_word(pc0 + 32'(4 * i)));
            check_order(name, exp.order, got[first + i].order);
            check_id_ex(name, exp, got[first + i]);
        end
    endtask

    task automatic reset_fetch();
        int tries;
        fill_memory();
        do_reset();
        check_mask("reset_fetch", 4'b0000, imem_rmask);
        tries = 0;
        while (imem_rmask == 4'b0000) begin
            if (id_ex.valid) stop_with_failure("id_ex became valid before any fetch");
            if (tries == 4) stop_with_failure("no fetch request after reset");
            tries++;
            @(negedge clk);
        end
        // the first request holds until its word lands in ir.
        while (!uut.if_id.valid) begin
            check_addr("reset_fetch", RESET_PC, imem_addr);
            check_mask("reset_fetch", 4'b1111, imem_rmask);
            if (id_ex.valid) stop_with_failure("id_ex valid before the first response");
            @(negedge clk);
        end
        if (id_ex.valid) stop_with_failure("id_ex valid while ir held the first word");
        wait_for_count(1);
        expect_run("reset_fetch", 0, RESET_PC, 64'd0, 1);
    endtask

    task automatic sequential_decode();
        fill_memory();
        for (int i = 0; i < SEQ_LEN; i++) mem[i] = SEQ_PROG[i];
        do_reset();
        wait_for_count(SEQ_LEN);
        expect_run("sequential_decode", 0, RESET_PC, 64'd0, SEQ_LEN);
    endtask

    task automatic stall_hold();
        id_ex_stage_reg_t held;
        fill_memory();
        do_reset();
        wait_for_count(3);
        stall = 1'b1;
        held  = id_ex;
        repeat (6) begin
            @(negedge clk);
            check_id_ex("stall_hold", held, id_ex);
            if (uut.if_id.valid && imem_rmask != 4'b0000)
                stop_with_failure("fetch request issued while ir was full and stalled");
        end
        stall = 1'b0;
        wait_for_count(STALL_LEN);
        expect_run("stall_hold", 0, RESET_PC, 64'd0, STALL_LEN);
    endtask

    task automatic redirect();
        logic [31:0] x;
        logic [31:0] target;
        int          k;
        int          j;
        fill_memory();
        lat_fixed = 4;
        do_reset();
        target = RESET_PC + 32'h200;
        // wait for a request in flight with ir empty.
        while (!(got.size() >= 2 && imem_rmask != 4'b0000 && !uut.if_id.valid))
            @(negedge clk);
        x        = imem_addr;
        k        = int'((x - RESET_PC) >> 2);
        pc_sel   = 1'b1;
        pc_br_jp = target;
        @(negedge clk);
        pc_sel = 1'b0;
        wait_for_count(k + 4);
        expect_run("redirect", 0, RESET_PC, 64'd0, k);
        expect_run("redirect", k, target, 64'(k), 4);
        j = 0;
        while (req_addrs[j] != x) j++;
        check_addr("redirect", target, req_addrs[j + 1]);
        lat_fixed = 0;
    endtask

    task automatic random_latency();
        fill_memory();
        for (int i = 0; i < RAND_LEN + 8; i++) mem[i] = random_inst();
        do_reset();
        while (got.size() < RAND_LEN) begin
            @(negedge clk);
            stall = (next_random() % 4) == 0;
        end
        stall = 1'b0;
        expect_run("random_latency", 0, RESET_PC, 64'd0, RAND_LEN);
    endtask

    initial begin
        rst      = 1'b1;
        stall    = 1'b0;
        pc_sel   = 1'b0;
        pc_br_jp = 32'h0;
        reset_fetch();
        sequential_decode();
        stall_hold();
        redirect();
        random_latency();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* rv32i_frontend.sv */
`timescale 1ns/1ps

module rv32i_frontend
import rv32i_types::*;
#(
    parameter logic [31:0] RESET_PC = 32'h6000_0000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             pc_sel,
    input  logic [31:0]      pc_br_jp,
    output logic [31:0]      imem_addr,
    output imem_rmask_t      imem_rmask,
    input  logic [31:0]      imem_rdata,
    input  logic             imem_resp,
    output id_ex_stage_reg_t id_ex
);

    if_id_stage_reg_t if_id;
    logic             load_ir;
    logic             slot_free;
    logic             id_ready;
    logic [31:0]      fetch_pc;
    logic [63:0]      fetch_order;

    // ir is free when empty or drained this cycle.
    assign slot_free = ~if_id.valid | id_ready;

    if_stage #(
        .RESET_PC(RESET_PC)
    ) fetch (
        .clk        (clk),
        .rst        (rst),
        .pc_sel     (pc_sel),
        .pc_br_jp   (pc_br_jp),
        .slot_free  (slot_free),
        .imem_addr  (imem_addr),
        .imem_rmask (imem_rmask),
        .imem_resp  (imem_resp),
        .load_ir    (load_ir),
        .fetch_pc   (fetch_pc),
        .fetch_order(fetch_order)
    );

    ir ir_reg (
        .clk    (clk),
        .rst    (rst),
        .load_ir(load_ir),
        .flush  (pc_sel),
        .hold   (stall),
        .in     (imem_rdata),
        .pc     (fetch_pc),
        .order  (fetch_order),
        .out    (if_id)
    );

    id_stage decode (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .flush   (pc_sel),
        .if_id   (if_id),
        .id_ready(id_ready),
        .id_ex   (id_ex)
    );

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage
import rv32i_isa::*;
import rv32i_types::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             flush,
    input  if_id_stage_reg_t if_id,
    output logic             id_ready,
    output id_ex_stage_reg_t id_ex
);

    id_ex_stage_reg_t dec;
    imm_fmt_t         fmt;
    logic [31:0]      imm;
    logic             reg_write;
    logic             mem_read;
    logic             mem_write;
    logic             branch;
    logic             jump;
    logic             illegal;

    assign id_ready = ~stall;

    // opcode to format and control bits.
    always_comb begin
        fmt       = fmt_none;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        illegal   = 1'b0;
        case (if_id.opcode)
            opc_lui, opc_auipc: begin
                fmt       = fmt_u;
                reg_write = 1'b1;
            end
            opc_jal: begin
                fmt       = fmt_j;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            opc_jalr: begin
                fmt       = fmt_i;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            opc_branch: begin
                fmt    = fmt_b;
                branch = 1'b1;
            end
            opc_load: begin
                fmt       = fmt_i;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            opc_store: begin
                fmt       = fmt_s;
                mem_write = 1'b1;
            end
            opc_op_imm: begin
                fmt       = fmt_i;
                reg_write = 1'b1;
            end
            opc_op: begin
                if (if_id.funct7 == funct7_base || if_id.funct7 == funct7_alt) begin
                    reg_write = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_misc_mem, opc_system: begin
                fmt = fmt_none;  // no register side effect here.
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i:   imm = if_id.i_imm;
            fmt_s:   imm = if_id.s_imm;
            fmt_b:   imm = if_id.b_imm;
            fmt_u:   imm = if_id.u_imm;
            fmt_j:   imm = if_id.j_imm;
            default: imm = 32'h0000_0000;
        endcase
    end

    always_comb begin
        dec.valid     = if_id.valid;
        dec.pc        = if_id.pc;
        dec.order     = if_id.order;
        dec.inst      = if_id.inst;
        dec.rs1_s     = if_id.rs1_s;
        dec.rs2_s     = if_id.rs2_s;
        dec.rd_s      = if_id.rd_s;
        dec.funct3    = if_id.funct3;
        dec.funct7    = if_id.funct7;
        dec.imm_fmt   = fmt;
        dec.imm       = imm;
        // writes to x0 are dropped.
        dec.reg_write = if_id.valid & reg_write & (if_id.rd_s != 5'd0);
        dec.mem_read  = if_id.valid & mem_read;
        dec.mem_write = if_id.valid & mem_write;
        dec.branch    = if_id.valid & branch;
        dec.jump      = if_id.valid & jump;
        dec.illegal   = if_id.valid & illegal;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= dec;
        end
    end

endmodule

/* if_stage.sv */
`timescale 1ns/1ps

module if_stage
import rv32i_types::*;
#(
    parameter logic [31:0] RESET_PC = 32'h6000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pc_sel,
    input  logic [31:0] pc_br_jp,
    input  logic        slot_free,
    output logic [31:0] imem_addr,
    output imem_rmask_t imem_rmask,
    input  logic        imem_resp,
    output logic        load_ir,
    output logic [31:0] fetch_pc,
    output logic [63:0] fetch_order
);

    typedef enum logic {
        s_reset,
        s_fetching
    } state_t;

    state_t      state, state_next;
    logic [31:0] pc;
    logic [31:0] redir_pc;
    logic [63:0] order;
    logic        busy;           // request outstanding.
    logic        redir_pending;
    logic        ir_full;        // mirrors the ir valid bit.
    logic        issue;
    logic        req_active;

    always_comb begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            s_reset: begin
                state_next = s_fetching;
            end
            s_fetching: begin
                // a redirect this cycle makes pc stale.
                issue = ~busy & slot_free & ~pc_sel;
            end
        endcase
    end

    assign req_active  = busy | issue;
    assign imem_addr   = pc;
    assign imem_rmask  = req_active ? 4'b1111 : 4'b0000;
    assign load_ir     = req_active & imem_resp & ~redir_pending & ~pc_sel;
    assign fetch_pc    = pc;
    assign fetch_order = order;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= s_reset;
            pc            <= RESET_PC;
            order         <= '0;
            busy          <= 1'b0;
            redir_pending <= 1'b0;
            ir_full       <= 1'b0;
        end else begin
            state <= state_next;
            busy  <= req_active & ~imem_resp;

            if (pc_sel) begin
                if (req_active && !imem_resp) begin
                    // address must hold until the response.
                    redir_pending <= 1'b1;
                    redir_pc      <= pc_br_jp;
                end else begin
                    redir_pending <= 1'b0;
                    pc            <= pc_br_jp;
                end
            end else if (req_active && imem_resp) begin
                redir_pending <= 1'b0;
                pc            <= redir_pending ? redir_pc : pc + 32'd4;
            end

            // the flushed ir entry gives its number back.
            if (pc_sel) begin
                if (ir_full) order <= order - 64'd1;
            end else if (load_ir) begin
                order <= order + 64'd1;
            end

            if (pc_sel) ir_full <= 1'b0;
            else if (load_ir) ir_full <= 1'b1;
            else if (slot_free) ir_full <= 1'b0;
        end
    end

endmodule

/* ir.sv */
`timescale 1ns/1ps

module ir
import rv32i_isa::*;
import rv32i_types::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             load_ir,
    input  logic             flush,
    input  logic             hold,
    input  logic [31:0]      in,
    input  logic [31:0]      pc,
    input  logic [63:0]      order,
    output if_id_stage_reg_t out
);

    logic        valid;
    logic [31:0] inst;
    logic [31:0] pc_q;
    logic [63:0] order_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else if (load_ir) begin
            valid <= 1'b1;
        end else if (!hold) begin
            valid <= 1'b0;  // consumed by decode.
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) begin
            inst    <= in;
            pc_q    <= pc;
            order_q <= order;
        end
    end

    always_comb begin
        out.valid  = valid;
        out.pc     = pc_q;
        out.order  = order_q;
        out.inst   = inst;
        out.opcode = opcode_t'(inst[6:0]);
        out.funct3 = inst[14:12];
        out.funct7 = inst[31:25];
        out.rs1_s  = inst[19:15];
        out.rs2_s  = inst[24:20];
        out.rd_s   = inst[11:7];
        // all immediates sign extend from bit 31.
        out.i_imm  = {{21{inst[31]}}, inst[30:20]};
        out.s_imm  = {{21{inst[31]}}, inst[30:25], inst[11:7]};
        out.b_imm  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        out.u_imm  = {inst[31:12], 12'h000};
        out.j_imm  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end

endmodule

/* rv32i_types.sv */
package rv32i_types;

    import rv32i_isa::*;

    typedef logic [3:0] imem_rmask_t;

    // instruction register contents, split into fields.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
        logic [31:0] inst;
        opcode_t     opcode;
        funct3_t     funct3;
        funct7_t     funct7;
        reg_idx_t    rs1_s;
        reg_idx_t    rs2_s;
        reg_idx_t    rd_s;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
    } if_id_stage_reg_t;

    // decoded record handed to execute.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
        logic [31:0] inst;
        reg_idx_t    rs1_s;
        reg_idx_t    rs2_s;
        reg_idx_t    rd_s;
        funct3_t     funct3;
        funct7_t     funct7;
        imm_fmt_t    imm_fmt;
        logic [31:0] imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        illegal;
    } id_ex_stage_reg_t;

endpackage

/* rv32i_isa.sv */
package rv32i_isa;

    // major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_jalr     = 7'b1100111,
        opc_branch   = 7'b1100011,
        opc_load     = 7'b0000011,
        opc_store    = 7'b0100011,
        opc_op_imm   = 7'b0010011,
        opc_op       = 7'b0110011,
        opc_misc_mem = 7'b0001111,  // fence.
        opc_system   = 7'b1110011   // ecall, ebreak, csr.
    } opcode_t;

    // which immediate an instruction carries.
    typedef enum logic [2:0] {
        fmt_none = 3'd0,
        fmt_i    = 3'd1,
        fmt_s    = 3'd2,
        fmt_b    = 3'd3,
        fmt_u    = 3'd4,
        fmt_j    = 3'd5
    } imm_fmt_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_idx_t;

    // funct7 on register-register ops.
    localparam funct7_t funct7_base = 7'b0000000;
    localparam funct7_t funct7_alt  = 7'b0100000;  // sub, sra.

endpackage
